// ==== design/neuronPkg.sv ====
package neuronPkg;

    ////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////

    // Pixel intensity, unsigned
    typedef logic [7:0] pixel_t;

    typedef logic signed [15:0] weight_t;

    // One lane input for one beat
    typedef struct packed {
        pixel_t  pixel;
        weight_t weight;
    } laneIn_t;

    typedef logic signed [31:0] laneAcc_t;

    // Neuron sum including bias
    typedef logic signed [43:0] sum_t;

    // Q8.8 values
    typedef logic signed [15:0] fixed_t;
    typedef logic [15:0] activation_t;

    typedef struct packed {
        fixed_t      preActivation;
        activation_t activation;
    } neuronResult_t;

    typedef enum logic [1:0] {
        sIdle,
        sAccumulate,
        sReduce,
        sHold
    } neuronState_e;

    ////////////////////////////////////////////////////////////
    // Sigmoid breakpoints and offsets, Q8.8
    ////////////////////////////////////////////////////////////

    localparam activation_t SIG_ONE      = 16'd256;
    localparam activation_t SIG_HALF     = 16'd128;
    localparam activation_t SIG_BREAK_1  = 16'd256;
    localparam activation_t SIG_BREAK_2  = 16'd608;
    localparam activation_t SIG_BREAK_3  = 16'd1280;
    localparam activation_t SIG_OFFSET_1 = 16'd160;
    localparam activation_t SIG_OFFSET_2 = 16'd216;

endpackage

// ==== design/productLane.sv ====
`timescale 1ns/1ps

module productLane import neuronPkg::*; (
    input  logic     CLK,
    input  logic     arstN,
    input  logic     beatValid,
    input  logic     firstBeat,
    input  laneIn_t  laneIn,
    output laneAcc_t acc
);

    laneAcc_t pixelExt;
    laneAcc_t weightExt;
    laneAcc_t product;

    // Pixel is unsigned, so pad with a zero before the signed multiply
    assign pixelExt  = laneAcc_t'($signed({1'b0, laneIn.pixel}));
    assign weightExt = laneAcc_t'(laneIn.weight);
    assign product   = pixelExt * weightExt;

    // First beat of a frame restarts the total
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            acc <= '0;
        end else if (beatValid) begin
            if (firstBeat) begin
                acc <= product;
            end else begin
                acc <= acc + product;
            end
        end
    end

endmodule

// ==== design/adderTree.sv ====
`timescale 1ns/1ps

module adderTree import neuronPkg::*; #(
    parameter int NUM_LANES = 28
) (
    input  logic                     CLK,
    input  logic                     arstN,
    input  logic                     reduceStart,
    input  laneAcc_t [NUM_LANES-1:0] accs,
    input  weight_t                  bias,
    output logic                     sumValid,
    output sum_t                     sum
);

    // Lanes plus bias, padded to a power of two
    localparam int TREE_STAGES = $clog2(NUM_LANES + 1);
    localparam int LEAVES      = 2 ** TREE_STAGES;

    sum_t leaf [LEAVES];
    // Heap order, node 0 is the root
    sum_t node [LEAVES-1];
    logic [TREE_STAGES-1:0] validPipe;

    genvar i;
    generate
        for (i = 0; i < LEAVES; i++) begin : genLeaf
            if (i < NUM_LANES) begin : genAcc
                assign leaf[i] = sum_t'($signed(accs[i]));
            end else if (i == NUM_LANES) begin : genBias
                assign leaf[i] = sum_t'($signed(bias));
            end else begin : genPad
                assign leaf[i] = '0;
            end
        end

        // One tree level per clock
        for (i = 0; i < LEAVES - 1; i++) begin : genNode
            if (2 * i + 1 >= LEAVES - 1) begin : genBottom
                always_ff @(posedge CLK) begin
                    node[i] <= leaf[2 * i + 2 - LEAVES] + leaf[2 * i + 3 - LEAVES];
                end
            end else begin : genInner
                always_ff @(posedge CLK) begin
                    node[i] <= node[2 * i + 1] + node[2 * i + 2];
                end
            end
        end
    endgenerate

    // Valid bit moves with the data
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[TREE_STAGES-2:0], reduceStart};
        end
    end

    assign sumValid = validPipe[TREE_STAGES-1];
    assign sum      = node[0];

    // A sum only appears a full tree depth after its start
    validLatency: assert property (@(posedge CLK) disable iff (!arstN)
        $rose(sumValid) |-> $past(reduceStart, TREE_STAGES));

endmodule

// ==== design/sigmoidPwl.sv ====
`timescale 1ns/1ps

module sigmoidPwl import neuronPkg::*; #(
    parameter int SCALE_SHIFT = 20
) (
    input  logic          CLK,
    input  logic          arstN,
    input  logic          sumValid,
    input  sum_t          sum,
    output logic          actValid,
    output neuronResult_t act
);

    typedef enum logic [1:0] {
        segCenter,
        segMid,
        segTail,
        segFlat
    } segment_e;

    sum_t        shifted;
    fixed_t      sat;
    logic [15:0] mag;
    segment_e    seg;

    logic        s1Valid;
    fixed_t      s1Pre;
    logic        s1Neg;
    logic [15:0] s1Mag;
    segment_e    s1Seg;
    activation_t y;

    ////////////////////////////////////////////////////////////
    // Stage 1: scale, saturate, fold to magnitude
    ////////////////////////////////////////////////////////////

    assign shifted = sum >>> SCALE_SHIFT;

    always_comb begin
        if (shifted[43:15] == '0 || shifted[43:15] == '1) begin
            sat = shifted[15:0];
        end else begin
            sat = shifted[43] ? 16'sh8000 : 16'sh7fff;
        end
    end

    // Unsigned, so -32768 folds to 32768 cleanly
    assign mag = sat[15] ? 16'(-sat) : 16'(sat);

    always_comb begin
        if (mag < SIG_BREAK_1) begin
            seg = segCenter;
        end else if (mag < SIG_BREAK_2) begin
            seg = segMid;
        end else if (mag < SIG_BREAK_3) begin
            seg = segTail;
        end else begin
            seg = segFlat;
        end
    end

    always_ff @(posedge CLK) begin
        s1Pre <= sat;
        s1Neg <= sat[15];
        s1Mag <= mag;
        s1Seg <= seg;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2: segment lines, mirror for negative input
    ////////////////////////////////////////////////////////////

    always_comb begin
        unique case (s1Seg)
            segCenter: y = (s1Mag >> 2) + SIG_HALF;
            segMid:    y = (s1Mag >> 3) + SIG_OFFSET_1;
            segTail:   y = (s1Mag >> 5) + SIG_OFFSET_2;
            default:   y = SIG_ONE;
        endcase
    end

    always_ff @(posedge CLK) begin
        act.preActivation <= s1Pre;
        act.activation    <= s1Neg ? SIG_ONE - y : y;
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            s1Valid  <= 1'b0;
            actValid <= 1'b0;
        end else begin
            s1Valid  <= sumValid;
            actValid <= s1Valid;
        end
    end

    activationRange: assert property (@(posedge CLK) disable iff (!arstN)
        actValid |-> act.activation <= SIG_ONE);

endmodule

// ==== design/neuronController.sv ====
`timescale 1ns/1ps

module neuronController import neuronPkg::*; (
    input  logic          CLK,
    input  logic          arstN,
    input  logic          beatValid,
    input  logic          lastBeat,
    input  logic          actValid,
    input  neuronResult_t act,
    output logic          firstBeat,
    output logic          reduceStart,
    output logic          dataRequest,
    output logic          resultValid,
    output neuronResult_t result
);

    neuronState_e state;
    neuronState_e nextState;
    logic         capture;

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        unique case (state)
            sIdle: begin
                // Single-beat frames skip accumulation
                if (beatValid) begin
                    nextState = lastBeat ? sReduce : sAccumulate;
                end
            end
            sAccumulate: begin
                if (beatValid && lastBeat) begin
                    nextState = sReduce;
                end
            end
            sReduce: begin
                nextState = sHold;
            end
            sHold: begin
                if (actValid) begin
                    nextState = sIdle;
                end
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    // Lanes load instead of add on the first beat
    assign firstBeat   = (state == sIdle);
    assign dataRequest = (state == sIdle) || (state == sAccumulate);
    assign reduceStart = (state == sReduce);

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    assign capture = (state == sHold) && actValid;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
            result      <= '0;
        end else begin
            resultValid <= capture;
            if (capture) begin
                result <= act;
            end
        end
    end

    // Lanes still hold the frame until the result is out
    noBeatWhileBusy: assert property (@(posedge CLK) disable iff (!arstN)
        beatValid |-> dataRequest);

endmodule

// ==== design/parallelNeuron.sv ====
`timescale 1ns/1ps

module parallelNeuron import neuronPkg::*; #(
    parameter int NUM_LANES   = 28,
    parameter int SCALE_SHIFT = 20
) (
    input  logic                    CLK,
    input  logic                    arstN,
    input  logic                    beatValid,
    input  logic                    lastBeat,
    input  laneIn_t [NUM_LANES-1:0] laneIn,
    input  weight_t                 bias,
    output logic                    dataRequest,
    output logic                    resultValid,
    output neuronResult_t           result
);

    logic                     beatAccept;
    logic                     firstBeat;
    logic                     reduceStart;
    logic                     sumValid;
    logic                     actValid;
    laneAcc_t [NUM_LANES-1:0] laneAccs;
    sum_t                     treeSum;
    neuronResult_t            sigResult;

    assign beatAccept = beatValid && dataRequest;

    // One MAC per pixel position
    for (genvar i = 0; i < NUM_LANES; i++) begin : genLane
        productLane i_lane (
            .CLK       (CLK),
            .arstN     (arstN),
            .beatValid (beatAccept),
            .firstBeat (firstBeat),
            .laneIn    (laneIn[i]),
            .acc       (laneAccs[i])
        );
    end

    adderTree #(
        .NUM_LANES (NUM_LANES)
    ) i_tree (
        .CLK         (CLK),
        .arstN       (arstN),
        .reduceStart (reduceStart),
        .accs        (laneAccs),
        .bias        (bias),
        .sumValid    (sumValid),
        .sum         (treeSum)
    );

    sigmoidPwl #(
        .SCALE_SHIFT (SCALE_SHIFT)
    ) i_sigmoid (
        .CLK      (CLK),
        .arstN    (arstN),
        .sumValid (sumValid),
        .sum      (treeSum),
        .actValid (actValid),
        .act      (sigResult)
    );

    neuronController i_ctrl (
        .CLK         (CLK),
        .arstN       (arstN),
        .beatValid   (beatValid),
        .lastBeat    (lastBeat),
        .actValid    (actValid),
        .act         (sigResult),
        .firstBeat   (firstBeat),
        .reduceStart (reduceStart),
        .dataRequest (dataRequest),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

// ==== testbench/tbParallelNeuron.sv ====
`timescale 1ns/1ps

module tbParallelNeuron import neuronPkg::*; ();

    localparam int NUM_LANES      = 28;
    localparam int SCALE_SHIFT    = 20;
    // Tree depth plus sigmoid stages plus output register
    localparam int RESULT_LATENCY = $clog2(NUM_LANES + 1) + 3;
    localparam int RANDOM_FRAMES  = 200;
    localparam int MULTI_FRAMES   = 200;
    localparam int SAT_BEATS      = 200;
    localparam int SYM_PAIRS      = 4;
    localparam int TOTAL_FRAMES   = RANDOM_FRAMES + MULTI_FRAMES + 3 + 2 * SYM_PAIRS;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (SAT_BEATS + 12) + 100;

    // Weight multiples per pair, the last two reach the middle and tail segments
    localparam int SYM_LOW [SYM_PAIRS]  = '{-3, -1, 2, 3};
    localparam int SYM_SPAN [SYM_PAIRS] = '{6, 2, 0, 0};

    typedef enum {
        kindRandom,
        kindPosMax,
        kindNegMax,
        kindZero,
        kindSym
    } frameKind_e;

    logic                    CLK;
    logic                    arstN;
    logic                    beatValid;
    logic                    lastBeat;
    laneIn_t [NUM_LANES-1:0] laneIn;
    weight_t                 bias;
    logic                    dataRequest;
    logic                    resultValid;
    neuronResult_t           result;

    longint        laneTotal [NUM_LANES];
    int            symK [8][NUM_LANES];
    int            cycleCount = 0;
    logic          prevResultValid = 1'b0;
    neuronResult_t lastResult;

    parallelNeuron i_dut (
        .CLK         (CLK),
        .arstN       (arstN),
        .beatValid   (beatValid),
        .lastBeat    (lastBeat),
        .laneIn      (laneIn),
        .bias        (bias),
        .dataRequest (dataRequest),
        .resultValid (resultValid),
        .result      (result)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic reportMismatch(input string what);
        stopWithFailure($sformatf("[ERROR] t=%0d ns: %s", $time, what));
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic neuronResult_t modelResult(input longint total);
        longint        scaled;
        int            x;
        int            m;
        int            y;
        neuronResult_t r;
        scaled = total >>> SCALE_SHIFT;
        if (scaled > 32767) begin
            x = 32767;
        end else if (scaled < -32768) begin
            x = -32768;
        end else begin
            x = int'(scaled);
        end
        m = (x < 0) ? -x : x;
        // Breakpoints 1.0, 2.375 and 5.0 in Q8.8
        if (m < 256) begin
            y = (m >> 2) + 128;
        end else if (m < 608) begin
            y = (m >> 3) + 160;
        end else if (m < 1280) begin
            y = (m >> 5) + 216;
        end else begin
            y = 256;
        end
        if (x < 0) begin
            y = 256 - y;
        end
        r.preActivation = 16'(x);
        r.activation    = 16'(y);
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Frame driver and result checker
    ////////////////////////////////////////////////////////////

    task automatic waitForResult(input neuronResult_t expected);
        int waited;
        waited = 0;
        while (!resultValid) begin
            assert (!dataRequest) else reportMismatch("dataRequest high while a frame reduces");
            assert (waited < RESULT_LATENCY) else reportMismatch("result did not arrive in time");
            @(posedge CLK);
            #2;
            waited++;
        end
        assert (waited == RESULT_LATENCY)
            else reportMismatch($sformatf("result latency %0d, expected %0d",
                                          waited, RESULT_LATENCY));
        assert (dataRequest) else reportMismatch("dataRequest low when the result arrived");
        assert (result.preActivation == expected.preActivation)
            else reportMismatch($sformatf("preActivation %0d, expected %0d",
                                          result.preActivation, expected.preActivation));
        assert (result.activation == expected.activation)
            else reportMismatch($sformatf("activation %0d, expected %0d",
                                          result.activation, expected.activation));
        lastResult = result;
    endtask

    task automatic runFrame(input frameKind_e kind, input int nBeats, input int maxGap,
                            input int sign);
        int     gap;
        int     pix;
        int     wgt;
        longint prod;
        longint total;
        bias = (kind == kindRandom) ? weight_t'($urandom_range(65535, 0)) : '0;
        for (int b = 0; b < nBeats; b++) begin
            gap = (maxGap > 0) ? int'($urandom_range(maxGap, 0)) : 0;
            repeat (gap) begin
                beatValid = 1'b0;
                lastBeat  = 1'b0;
                @(posedge CLK);
                #2;
            end
            assert (dataRequest) else reportMismatch("dataRequest low during an open frame");
            for (int i = 0; i < NUM_LANES; i++) begin
                wgt = int'($urandom_range(65535, 0)) - 32768;
                pix = int'($urandom_range(255, 0));
                case (kind)
                    kindPosMax: begin
                        pix = 255;
                        wgt = 32767;
                    end
                    kindNegMax: begin
                        pix = 255;
                        wgt = -32768;
                    end
                    kindZero: pix = 0;
                    // Products land on multiples of 2^20, so the shift is exact
                    kindSym: begin
                        pix = 128;
                        wgt = sign * symK[b][i] * 8192;
                    end
                    default: ;
                endcase
                laneIn[i].pixel  = 8'(pix);
                laneIn[i].weight = 16'(wgt);
                prod = longint'(pix) * longint'(wgt);
                laneTotal[i] = (b == 0) ? prod : laneTotal[i] + prod;
            end
            beatValid = 1'b1;
            lastBeat  = (b == nBeats - 1);
            @(posedge CLK);
            #2;
        end
        beatValid = 1'b0;
        lastBeat  = 1'b0;
        total = longint'(bias);
        for (int i = 0; i < NUM_LANES; i++) begin
            total += laneTotal[i];
        end
        waitForResult(modelResult(total));
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            stopWithFailure($sformatf("Timeout: the run did not finish within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    always @(negedge CLK) begin
        if (arstN) begin
            assert (!(resultValid && prevResultValid))
                else reportMismatch("resultValid high for two cycles in a row");
        end
        prevResultValid = resultValid;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int            pairBeats;
        neuronResult_t firstOfPair;
        void'($urandom(32'h3d47));
        arstN     = 1'b0;
        beatValid = 1'b0;
        lastBeat  = 1'b0;
        laneIn    = '0;
        bias      = '0;
        repeat (2) @(posedge CLK);
        #2;
        arstN = 1'b1;

        assert (dataRequest) else reportMismatch("dataRequest low after reset");
        assert (!resultValid) else reportMismatch("resultValid high after reset");
        assert (result == '0) else reportMismatch("result not zero after reset");

        repeat (RANDOM_FRAMES) runFrame(kindRandom, 1, 0, 1);
        repeat (MULTI_FRAMES) runFrame(kindRandom, int'($urandom_range(8, 1)), 3, 1);

        // Long frames drive the sum far past the Q8.8 range
        runFrame(kindPosMax, SAT_BEATS, 0, 1);
        assert (lastResult.preActivation == 16'sh7fff && lastResult.activation == 16'd256)
            else reportMismatch("positive saturation gave the wrong result");
        runFrame(kindNegMax, SAT_BEATS, 0, 1);
        assert (lastResult.preActivation == 16'sh8000 && lastResult.activation == 16'd0)
            else reportMismatch("negative saturation gave the wrong result");

        runFrame(kindZero, 1, 0, 1);
        assert (lastResult.activation == 16'd128) else reportMismatch("midpoint is not 128");

        for (int p = 0; p < SYM_PAIRS; p++) begin
            for (int b = 0; b < 8; b++) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    symK[b][i] = SYM_LOW[p] + int'($urandom_range(SYM_SPAN[p], 0));
                end
            end
            // Full-length frames give 448 and 672 for the fixed multiples
            pairBeats = (SYM_SPAN[p] == 0) ? 8 : int'($urandom_range(8, 1));
            runFrame(kindSym, pairBeats, 1, 1);
            firstOfPair = lastResult;
            runFrame(kindSym, pairBeats, 1, -1);
            assert (int'(firstOfPair.activation) + int'(lastResult.activation) == 256)
                else reportMismatch("mirrored frames do not sum to 256");
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== parallelNeuron.f ====
design/neuronPkg.sv
design/productLane.sv
design/adderTree.sv
design/sigmoidPwl.sv
design/neuronController.sv
design/parallelNeuron.sv
testbench/tbParallelNeuron.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbParallelNeuron -f parallelNeuron.f

# The simulator's own exit status is masked by tee, the log decides
./obj_dir/VtbParallelNeuron | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
